// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the SPI register slave testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f src.f \
	--top-module tb_spi_regs -o sim_tb_spi_regs
./obj_dir/sim_tb_spi_regs | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	echo "run_sim: failures found in sim.log"
	exit 1
fi
echo "run_sim: no failures in sim.log"

// ==== source/reg_arbiter.sv ====
/*
 * Round-robin arbiter giving two command framers access to one register bank.
 * Steers the bank response back to the port that was granted.
 */
`timescale 1ns/1ps
`default_nettype none

module reg_arbiter (
	input  logic				sys_clk,
	input  logic				sys_rst_n,
	input  logic [1:0]			req,
	input  spi_regs_pkg::reg_req_t [1:0]	req_data,
	output logic [1:0]			gnt,
	output spi_regs_pkg::reg_rsp_t [1:0]	rsp,
	output spi_regs_pkg::reg_req_t		bank_req,
	output logic				bank_en,
	input  spi_regs_pkg::reg_rsp_t		bank_rsp
);

	logic [1:0]	elig;		// requests not granted this cycle
	logic		sel;
	logic		last;		// last winner
	logic		rsp_owner;	// port owning the response in flight

	assign elig = req & ~gnt;	// req still high the cycle of gnt
	assign sel = (elig == 2'b11) ? ~last : elig[1];

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			gnt <= 2'b00;
			bank_en <= 1'b0;
			last <= 1'b1;		// port 0 wins first tie
			rsp_owner <= 1'b0;
		end else begin
			gnt <= 2'b00;
			bank_en <= 1'b0;
			if (|elig) begin
				gnt[sel] <= 1'b1;
				bank_en <= 1'b1;
				last <= sel;
			end
			if (bank_en)
				rsp_owner <= last;	// aligns with bank_rsp
		end
	end

	always_ff @(posedge sys_clk) begin
		if (|elig)
			bank_req <= req_data[sel];
	end

	always_comb begin
		rsp[0].valid = bank_rsp.valid & ~rsp_owner;
		rsp[0].rdata = bank_rsp.rdata;
		rsp[1].valid = bank_rsp.valid & rsp_owner;
		rsp[1].rdata = bank_rsp.rdata;
	end

endmodule

`default_nettype wire

// ==== source/reg_bank.sv ====
/*
 * Shared register bank, one byte per address.
 * Writes land on bank_en; reads return one cycle later with valid set.
 */
`timescale 1ns/1ps
`default_nettype none
`include "spi_regs_cfg.svh"

module reg_bank (
	input  logic			sys_clk,
	input  logic			sys_rst_n,
	input  spi_regs_pkg::reg_req_t	bank_req,
	input  logic			bank_en,
	output spi_regs_pkg::reg_rsp_t	bank_rsp
);

	logic [7:0]	mem [`SPI_REG_NUM];
	logic		rsp_valid;
	logic [7:0]	rsp_rdata;

	assign bank_rsp = '{valid: rsp_valid, rdata: rsp_rdata};

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			for (int i = 0; i < `SPI_REG_NUM; i++)
				mem[i] <= 8'h00;	// unwritten regs read zero
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= bank_en & ~bank_req.wr;	// reads only
			if (bank_en && bank_req.wr)
				mem[bank_req.addr] <= bank_req.wdata;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (bank_en)
			rsp_rdata <= mem[bank_req.addr];
	end

endmodule

`default_nettype wire

// ==== source/spi_cmd_port.sv ====
/*
 * Command framer behind one SPI slave front end.
 * Decodes the command byte, fetches read data and issues bank writes.
 */
`timescale 1ns/1ps
`default_nettype none
`include "spi_regs_cfg.svh"

module spi_cmd_port (
	input  logic			sys_clk,
	input  logic			sys_rst_n,
	input  logic [7:0]		rx_byte,
	input  logic			rx_strobe,
	input  logic			frame_start,
	input  logic			frame_abort,
	output logic [7:0]		tx_byte,
	output logic			tx_load,
	output logic			req,		// held until gnt
	output spi_regs_pkg::reg_req_t	req_data,
	input  logic			gnt,		// one-cycle grant
	input  spi_regs_pkg::reg_rsp_t	rsp
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_CMD,		// shifting command byte, ID going out
		S_DATA,		// shifting data byte
		S_DONE		// waiting for cs high
	} state_t;

	state_t	state;
	logic	rd_load;	// read data arrived for this frame

	assign rd_load = (state == S_DATA) & rsp.valid & ~req_data.wr;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state <= S_IDLE;
			req <= 1'b0;
			tx_load <= 1'b0;
		end else begin
			tx_load <= 1'b0;
			if (gnt)
				req <= 1'b0;		// drop the cycle after gnt
			if (frame_start) begin
				state <= S_CMD;
				tx_load <= 1'b1;	// ID byte
			end else if (frame_abort) begin
				state <= S_IDLE;	// no write issued
			end else begin
				case (state)
					S_CMD: if (rx_strobe) begin
						state <= S_DATA;
						if (!rx_byte[spi_regs_pkg::CMD_WR_BIT])
							req <= 1'b1;	// fetch read data now
					end
					S_DATA: begin
						if (rd_load)
							tx_load <= 1'b1;
						if (rx_strobe) begin
							state <= S_DONE;
							if (req_data.wr)
								req <= 1'b1;	// commit write
						end
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (frame_start)
			tx_byte <= `SPI_ID_BYTE;
		else if (rd_load)
			tx_byte <= rsp.rdata;
		if (state == S_CMD && rx_strobe) begin
			req_data.wr <= rx_byte[spi_regs_pkg::CMD_WR_BIT];
			req_data.addr <= rx_byte[`SPI_REG_AW-1:0];	// bits 6:4 dropped
		end
		if (state == S_DATA && rx_strobe)
			req_data.wdata <= rx_byte;
	end

endmodule

`default_nettype wire

// ==== source/spi_regs_cfg.svh ====
/*
 * Build-time configuration of the dual-host SPI register slave.
 * Included by the package, the RTL and the testbench for mode, ID and bank size.
 */
`ifndef SPI_REGS_CFG_SVH
`define SPI_REGS_CFG_SVH

`define SPI_CPOL	1'b1	// sclk idle level
`define SPI_CPHA	1'b1	// sample on trailing edge

`define SPI_ID_BYTE	8'hA5	// returned during every command byte

`define SPI_REG_AW	4	// register address bits
`define SPI_REG_NUM	16	// bytes in the shared bank

`endif

// ==== source/spi_regs_pkg.sv ====
/*
 * Shared types of the SPI register slave.
 * Request/response structs between the command framers, arbiter and bank.
 */
`default_nettype none
`include "spi_regs_cfg.svh"

package spi_regs_pkg;

	// write flag is bit 7 of the command byte, address in 3:0, 6:4 ignored
	localparam int CMD_WR_BIT = 7;

	typedef struct packed {
		logic				wr;	// 1 = write, 0 = read
		logic [`SPI_REG_AW-1:0]	addr;	// register index
		logic [7:0]			wdata;	// write payload
	} reg_req_t;

	typedef struct packed {
		logic		valid;	// read data present this cycle
		logic [7:0]	rdata;	// register contents
	} reg_rsp_t;

endpackage

`default_nettype wire

// ==== source/spi_regs_top.sv ====
/*
 * Dual-host SPI register slave top level.
 * Port a and port b each reach the shared 16 x 8 bank through the arbiter.
 */
`timescale 1ns/1ps
`default_nettype none
`include "spi_regs_cfg.svh"

module spi_regs_top (
	input  logic	sys_clk,
	input  logic	sys_rst_n,
	input  logic	cs_a,
	input  logic	sclk_a,
	input  logic	mosi_a,
	output logic	miso_a,
	input  logic	cs_b,
	input  logic	sclk_b,
	input  logic	mosi_b,
	output logic	miso_b
);

	logic [1:0]			cs_v;		// index 0 = port a
	logic [1:0]			sclk_v;
	logic [1:0]			mosi_v;
	logic [1:0]			miso_v;
	logic [1:0][7:0]		rx_byte;
	logic [1:0][7:0]		tx_byte;
	logic [1:0]			rx_strobe;
	logic [1:0]			tx_load;
	logic [1:0]			frame_start;
	logic [1:0]			frame_abort;
	logic [1:0]			req;
	logic [1:0]			gnt;
	spi_regs_pkg::reg_req_t [1:0]	req_data;
	spi_regs_pkg::reg_rsp_t [1:0]	rsp;
	spi_regs_pkg::reg_req_t		bank_req;
	spi_regs_pkg::reg_rsp_t		bank_rsp;
	logic				bank_en;

	assign cs_v = {cs_b, cs_a};
	assign sclk_v = {sclk_b, sclk_a};
	assign mosi_v = {mosi_b, mosi_a};
	assign miso_a = miso_v[0];
	assign miso_b = miso_v[1];

	for (genvar p = 0; p < 2; p++) begin : g_port
		spi_slave #(.CPOL(`SPI_CPOL), .CPHA(`SPI_CPHA)) u_slave (
			.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
			.cs(cs_v[p]), .sclk(sclk_v[p]), .mosi(mosi_v[p]), .miso(miso_v[p]),
			.tx_byte(tx_byte[p]), .tx_load(tx_load[p]),
			.rx_byte(rx_byte[p]), .rx_strobe(rx_strobe[p]),
			.frame_start(frame_start[p]), .frame_abort(frame_abort[p])
		);

		spi_cmd_port u_cmd (
			.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
			.rx_byte(rx_byte[p]), .rx_strobe(rx_strobe[p]),
			.frame_start(frame_start[p]), .frame_abort(frame_abort[p]),
			.tx_byte(tx_byte[p]), .tx_load(tx_load[p]),
			.req(req[p]), .req_data(req_data[p]), .gnt(gnt[p]), .rsp(rsp[p])
		);
	end

	reg_arbiter u_arb (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.req(req), .req_data(req_data), .gnt(gnt), .rsp(rsp),
		.bank_req(bank_req), .bank_en(bank_en), .bank_rsp(bank_rsp)
	);

	reg_bank u_bank (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.bank_req(bank_req), .bank_en(bank_en), .bank_rsp(bank_rsp)
	);

endmodule

`default_nettype wire

// ==== source/spi_slave.sv ====
/*
 * Oversampling SPI slave front end, clocked by sys_clk.
 * Pins go through 2-flop synchronizers; bytes are shifted per CPOL/CPHA.
 */
`timescale 1ns/1ps
`default_nettype none

module spi_slave #(
	parameter logic CPOL = 1'b1,	// sclk idle level
	parameter logic CPHA = 1'b1	// 1 = sample on trailing edge
) (
	input  logic		sys_clk,
	input  logic		sys_rst_n,
	input  logic		cs,		// active low chip select
	input  logic		sclk,
	input  logic		mosi,
	output logic		miso,
	input  logic [7:0]	tx_byte,	// next byte to shift out
	input  logic		tx_load,	// load pulse for tx_byte
	output logic [7:0]	rx_byte,
	output logic		rx_strobe,	// 8th bit sampled
	output logic		frame_start,	// cs fell
	output logic		frame_abort	// cs rose mid-byte
);

	logic [1:0]	cs_sync;	// pin synchronizers
	logic [1:0]	sclk_sync;
	logic [1:0]	mosi_sync;
	logic		cs_d;		// previous synced levels
	logic		sclk_d;
	logic		cs_fall;
	logic		cs_rise;
	logic		sclk_rise;
	logic		sclk_fall;
	logic		lead_edge;	// leaving idle level
	logic		trail_edge;	// returning to idle level
	logic		sample_edge;
	logic		shift_edge;
	logic [2:0]	bit_cnt;	// bits sampled in current byte
	logic [7:0]	rx_shift;
	logic [7:0]	tx_shift;
	logic		miso_r;

	assign cs_fall = cs_d & ~cs_sync[1];
	assign cs_rise = ~cs_d & cs_sync[1];
	assign sclk_rise = ~sclk_d & sclk_sync[1];
	assign sclk_fall = sclk_d & ~sclk_sync[1];

	assign lead_edge = CPOL ? sclk_fall : sclk_rise;
	assign trail_edge = CPOL ? sclk_rise : sclk_fall;
	assign sample_edge = (CPHA ? trail_edge : lead_edge) & ~cs_sync[1];	// only inside a frame
	assign shift_edge = (CPHA ? lead_edge : trail_edge) & ~cs_sync[1];

	assign rx_byte = rx_shift;
	assign miso = miso_r;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cs_sync <= 2'b11;		// deselected
			sclk_sync <= {2{CPOL}};
			mosi_sync <= 2'b00;
			cs_d <= 1'b1;
			sclk_d <= CPOL;
		end else begin
			cs_sync <= {cs_sync[0], cs};
			sclk_sync <= {sclk_sync[0], sclk};
			mosi_sync <= {mosi_sync[0], mosi};
			cs_d <= cs_sync[1];
			sclk_d <= sclk_sync[1];
		end
	end

	// frame control and bit counting
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			bit_cnt <= 3'd0;
			rx_strobe <= 1'b0;
			frame_start <= 1'b0;
			frame_abort <= 1'b0;
		end else begin
			frame_start <= cs_fall;
			frame_abort <= cs_rise & (bit_cnt != 3'd0);	// partial byte only
			rx_strobe <= sample_edge & (bit_cnt == 3'd7);
			if (cs_fall)
				bit_cnt <= 3'd0;
			else if (sample_edge)
				bit_cnt <= bit_cnt + 3'd1;	// wraps after 8 bits
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sample_edge)
			rx_shift <= {rx_shift[6:0], mosi_sync[1]};	// msb first
	end

	// tx path; on CPHA 0 the msb goes out at load and the byte boundary edge is skipped
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			miso_r <= 1'b0;
		end else if (tx_load) begin
			if (!CPHA)
				miso_r <= tx_byte[7];
		end else if (shift_edge && (CPHA || bit_cnt != 3'd0)) begin
			miso_r <= tx_shift[7];
		end
	end

	always_ff @(posedge sys_clk) begin
		if (tx_load)
			tx_shift <= CPHA ? tx_byte : {tx_byte[6:0], 1'b0};
		else if (shift_edge && (CPHA || bit_cnt != 3'd0))
			tx_shift <= {tx_shift[6:0], 1'b0};
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+source
source/spi_regs_pkg.sv
source/spi_slave.sv
source/spi_cmd_port.sv
source/reg_arbiter.sv
source/reg_bank.sv
source/spi_regs_top.sv
tests/tb_spi_regs.sv

// ==== tests/spi_regs_golden.txt ====
# kind: T single, P runs with the next P line, A aborts after 4 data bits, C frame counts a b
# kind port cmd data exp_id exp_rdata (exp_rdata is checked on reads only)
T 0 03 00 a5 00
T 1 0c 00 a5 00
T 0 81 5a a5 00
T 0 01 00 a5 5a
T 1 f2 c3 a5 00
P 0 84 11 a5 00
P 1 84 22 a5 00
T 0 72 00 a5 c3
T 0 04 00 a5 22
P 0 01 00 a5 5a
P 1 72 00 a5 c3
P 0 85 33 a5 00
P 1 85 44 a5 00
T 1 05 00 a5 33
A 0 81 ff a5 00
T 0 01 00 a5 5a
T 1 0f 00 a5 00
T 1 8f 9e a5 00
T 0 0f 00 a5 9e
C 10 8

// ==== tests/tb_spi_regs.sv ====
/*
 * Testbench for the dual-host SPI register slave.
 * Bit-bangs both SPI hosts from the golden file and checks miso bytes and frame counts.
 */
`timescale 1ns/1ps
`default_nettype none
`include "spi_regs_cfg.svh"

module tb_spi_regs;

	logic		sys_clk;
	logic		sys_rst_n;
	logic [1:0]	cs_pin;		// index 0 = port a
	logic [1:0]	sclk_pin;
	logic [1:0]	mosi_pin;
	logic		miso_a;
	logic		miso_b;
	int		byte_errs;
	int		count_errs;
	int		other_errs;
	int		frames [2];	// completed frames seen at each framer
	int		rx_bytes [2];	// bytes received in the current frame

	spi_regs_top dut0 (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.cs_a(cs_pin[0]), .sclk_a(sclk_pin[0]), .mosi_a(mosi_pin[0]), .miso_a(miso_a),
		.cs_b(cs_pin[1]), .sclk_b(sclk_pin[1]), .mosi_b(mosi_pin[1]), .miso_b(miso_b)
	);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;	// 4 ns period
	end

	// whole-run limit
	initial begin : watchdog
		repeat (200000) @(posedge sys_clk);
		$display("timeout: run did not reach its end within 200000 cycles");
		$display("SIMULATION FAILED");
		$finish;
	end

	// a frame counts once its framer has seen both bytes
	always @(negedge sys_clk) begin
		for (int p = 0; p < 2; p++) begin
			if (dut0.frame_start[p]) begin
				rx_bytes[p] = 0;
			end else if (dut0.rx_strobe[p]) begin
				rx_bytes[p] = rx_bytes[p] + 1;
				if (rx_bytes[p] == 2)
					frames[p] = frames[p] + 1;
			end
		end
	end

	function automatic logic miso_of(input bit p);
		return p ? miso_b : miso_a;
	endfunction

	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++)
			@(negedge sys_clk);	// pins move on falling edge only
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("ERROR %s got 8'h%02h expected 8'h%02h", name, got, exp);
			byte_errs++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
			count_errs++;
		end
	endtask

	// one byte or a partial byte, msb first, host side of the CPOL/CPHA mode
	task automatic shift_byte(input bit p, input logic [7:0] tx, input int nbits,
			input int half, output logic [7:0] rx);
		logic [7:0] sh;
		sh = tx;
		rx = 8'h00;
		for (int i = 0; i < nbits; i++) begin
			if (`SPI_CPHA)
				sclk_pin[p] = ~`SPI_CPOL;	// leading edge, slave shifts
			mosi_pin[p] = sh[7];
			sh = {sh[6:0], 1'b0};
			wait_cycles(half);
			rx = {rx[6:0], miso_of(p)};	// sampled right at the sampling edge
			sclk_pin[p] = `SPI_CPHA ? `SPI_CPOL : ~`SPI_CPOL;
			wait_cycles(half);
			if (!`SPI_CPHA)
				sclk_pin[p] = `SPI_CPOL;	// trailing edge for mode 0/2
		end
	endtask

	task automatic run_transaction(input bit p, input logic [7:0] cmd, input logic [7:0] data,
			input logic [7:0] exp_id, input logic [7:0] exp_rd, input int data_bits,
			input int half);
		logic [7:0]	rx_cmd;
		logic [7:0]	rx_data;
		string		nm;
		nm = p ? "miso_b" : "miso_a";
		cs_pin[p] = 1'b0;
		wait_cycles(half);		// room for the ID load
		shift_byte(p, cmd, 8, half, rx_cmd);
		shift_byte(p, data, data_bits, half, rx_data);	// short count aborts the frame
		cs_pin[p] = 1'b1;
		wait_cycles(half);
		check_byte({nm, " cmd byte"}, rx_cmd, exp_id);
		if (data_bits == 8 && !cmd[spi_regs_pkg::CMD_WR_BIT])
			check_byte({nm, " read data"}, rx_data, exp_rd);
	endtask

	initial begin : main_seq
		string		kind;
		int		fd;
		int		code;
		int		lines;
		int		port;
		int		half;
		int		exp_a;
		int		exp_b;
		logic [7:0]	cmd;
		logic [7:0]	data;
		logic [7:0]	exp_id;
		logic [7:0]	exp_rd;
		bit		have_pend;	// first line of a pair seen
		bit		pend_p;
		logic [7:0]	pend_cmd;
		logic [7:0]	pend_data;
		logic [7:0]	pend_id;
		logic [7:0]	pend_rd;
		logic [1023:0]	rest;

		sys_rst_n = 1'b0;
		cs_pin = 2'b11;
		sclk_pin = {2{`SPI_CPOL}};
		mosi_pin = 2'b00;
		byte_errs = 0;
		count_errs = 0;
		other_errs = 0;
		frames[0] = 0;
		frames[1] = 0;
		rx_bytes[0] = 0;
		rx_bytes[1] = 0;
		have_pend = 1'b0;
		void'($urandom(32'h48cd4238));
		wait_cycles(8);
		sys_rst_n = 1'b1;
		wait_cycles(4);

		fd = $fopen("tests/spi_regs_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open tests/spi_regs_golden.txt");
			other_errs++;
		end else begin
			lines = 0;
			while (lines < 100) begin	// bounded read loop
				code = $fscanf(fd, "%s", kind);
				if (code != 1)
					break;
				lines++;
				if (kind == "#") begin
					code = $fgets(rest, fd);	// comment line
				end else if (kind == "C") begin
					code = $fscanf(fd, "%d %d", exp_a, exp_b);
					check_count("frames port a", frames[0], exp_a);
					check_count("frames port b", frames[1], exp_b);
				end else begin
					code = $fscanf(fd, "%d %h %h %h %h", port, cmd, data, exp_id, exp_rd);
					half = $urandom_range(12, 8);
					if (kind == "P" && !have_pend) begin
						have_pend = 1'b1;
						pend_p = port[0];
						pend_cmd = cmd;
						pend_data = data;
						pend_id = exp_id;
						pend_rd = exp_rd;
					end else if (kind == "P") begin
						have_pend = 1'b0;
						wait_cycles($urandom_range(7, 0));
						fork	// same start cycle, same sclk rate
							run_transaction(pend_p, pend_cmd, pend_data, pend_id,
								pend_rd, 8, half);
							run_transaction(port[0], cmd, data, exp_id, exp_rd, 8, half);
						join
					end else if (kind == "T" || kind == "A") begin
						wait_cycles($urandom_range(7, 0));
						run_transaction(port[0], cmd, data, exp_id, exp_rd,
							(kind == "A") ? 4 : 8, half);
					end else begin
						$display("golden file line %0d has unknown kind %s", lines, kind);
						other_errs++;
					end
				end
			end
			$fclose(fd);
			if (have_pend) begin
				$display("golden file ends inside a paired transaction");
				other_errs++;
			end
		end

		$display("errors: byte=%0d count=%0d other=%0d", byte_errs, count_errs, other_errs);
		if (byte_errs + count_errs + other_errs == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire
